//--- verilog/fft_pkg.sv
package fft_pkg;

  // transform size
  localparam int fft_points = 16;
  localparam int fft_addr_w = 4;
  localparam int fft_stages = 4;
  localparam int stage_w = 2;

  // fixed-point format
  localparam int sample_w = 16;
  localparam int twiddle_frac = 14;

  // product width and the wider sum width ahead of the halving shift
  localparam int prod_w = 2 * sample_w;
  localparam int acc_w = sample_w + 2;

  // butterfly pipeline depth, input valid to first result
  localparam int bfly_latency = 3;

  typedef logic [fft_addr_w-1:0] fft_addr_t;
  typedef logic [fft_addr_w-2:0] tw_addr_t;
  typedef logic [stage_w-1:0] stage_t;

  typedef struct packed {
    logic signed [sample_w-1:0] re;
    logic signed [sample_w-1:0] im;
  } cplx_t;

  typedef enum logic [2:0] {
    phase_idle,
    phase_prepare,
    phase_butterfly,
    phase_drain,
    phase_arrange,
    phase_done
  } fft_phase_t;

  // reverse the bits of a point index
  function automatic fft_addr_t bit_rev(input fft_addr_t a);
    fft_addr_t r;
    for (int i = 0; i < fft_addr_w; i++) begin
      r[i] = a[fft_addr_w-1-i];
    end
    return r;
  endfunction

endpackage

//--- verilog/fft_sample_ram.sv
module fft_sample_ram (
  input  logic            clk,
  input  logic            we,
  input  fft_pkg::fft_addr_t addr,
  input  fft_pkg::cplx_t  wdata,
  output fft_pkg::cplx_t  rdata
);
  import fft_pkg::*;

  cplx_t mem [fft_points];

  // read returns the old word on a write cycle
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

endmodule

//--- verilog/fft_twiddle_rom.sv
module fft_twiddle_rom (
  input  logic              clk,
  input  fft_pkg::tw_addr_t addr,
  output fft_pkg::cplx_t    twiddle
);
  import fft_pkg::*;

  cplx_t entry;

  // cos and -sin of 2*pi*k/16, scaled by 2^14
  always_comb begin
    case (addr)
      3'd0:    entry = '{re: 16'sd16384, im: 16'sd0};
      3'd1:    entry = '{re: 16'sd15137, im: -16'sd6270};
      3'd2:    entry = '{re: 16'sd11585, im: -16'sd11585};
      3'd3:    entry = '{re: 16'sd6270, im: -16'sd15137};
      3'd4:    entry = '{re: 16'sd0, im: -16'sd16384};
      3'd5:    entry = '{re: -16'sd6270, im: -16'sd15137};
      3'd6:    entry = '{re: -16'sd11585, im: -16'sd11585};
      default: entry = '{re: -16'sd15137, im: -16'sd6270};
    endcase
  end

  // same one-cycle latency as the sample memories
  always_ff @(posedge clk) begin
    twiddle <= entry;
  end

endmodule

//--- verilog/fft_butterfly.sv
module fft_butterfly (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           in_valid,
  input  fft_pkg::cplx_t top,
  input  fft_pkg::cplx_t bottom,
  input  fft_pkg::cplx_t twiddle,
  output logic           out_valid,
  output fft_pkg::cplx_t result
);
  import fft_pkg::*;

  logic                     v1;
  logic                     v2;
  logic                     hold_pending;
  logic signed [prod_w-1:0] p_rr;
  logic signed [prod_w-1:0] p_ii;
  logic signed [prod_w-1:0] p_ri;
  logic signed [prod_w-1:0] p_ir;
  logic signed [prod_w-1:0] mul_re;
  logic signed [prod_w-1:0] mul_im;
  logic signed [acc_w-1:0]  prod_re;
  logic signed [acc_w-1:0]  prod_im;
  logic signed [acc_w-1:0]  sum_re;
  logic signed [acc_w-1:0]  sum_im;
  logic signed [acc_w-1:0]  dif_re;
  logic signed [acc_w-1:0]  dif_im;
  cplx_t                    top_s1;
  cplx_t                    top_s2;
  cplx_t                    dif_hold;

  assign mul_re = p_rr - p_ii;
  assign mul_im = p_ri + p_ir;

  assign sum_re = acc_w'(top_s2.re) + prod_re;
  assign sum_im = acc_w'(top_s2.im) + prod_im;
  assign dif_re = acc_w'(top_s2.re) - prod_re;
  assign dif_im = acc_w'(top_s2.im) - prod_im;

  // stage 1 partial products, stage 2 drop the twiddle fraction
  always_ff @(posedge clk) begin
    p_rr    <= bottom.re * twiddle.re;
    p_ii    <= bottom.im * twiddle.im;
    p_ri    <= bottom.re * twiddle.im;
    p_ir    <= bottom.im * twiddle.re;
    top_s1  <= top;
    prod_re <= mul_re[twiddle_frac +: acc_w];
    prod_im <= mul_im[twiddle_frac +: acc_w];
    top_s2  <= top_s1;
  end

  // stage 3 halves sum and difference, difference follows one cycle later
  always_ff @(posedge clk) begin
    if (v2) begin
      result.re   <= sum_re[sample_w:1];
      result.im   <= sum_im[sample_w:1];
      dif_hold.re <= dif_re[sample_w:1];
      dif_hold.im <= dif_im[sample_w:1];
    end else if (hold_pending) begin
      result <= dif_hold;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      v1           <= 1'b0;
      v2           <= 1'b0;
      hold_pending <= 1'b0;
      out_valid    <= 1'b0;
    end else begin
      v1           <= in_valid;
      v2           <= v1;
      hold_pending <= v2;
      out_valid    <= v2 | hold_pending;
    end
  end

endmodule

//--- verilog/fft_sequencer.sv
module fft_sequencer (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  input  logic                phase_last,
  output fft_pkg::fft_phase_t phase,
  output fft_pkg::stage_t     stage,
  output logic                busy,
  output logic                done
);
  import fft_pkg::*;

  fft_phase_t phase_nxt;
  stage_t     stage_nxt;
  logic       last_stage;

  assign last_stage = (stage == stage_t'(fft_stages - 1));

  always_comb begin
    phase_nxt = phase;
    stage_nxt = stage;
    case (phase)
      phase_idle: begin
        if (start) begin
          phase_nxt = phase_prepare;
          stage_nxt = '0;
        end
      end
      phase_prepare: begin
        if (phase_last) begin
          phase_nxt = phase_butterfly;
        end
      end
      phase_butterfly: begin
        if (phase_last) begin
          phase_nxt = phase_drain;
        end
      end
      phase_drain: begin
        if (phase_last) begin
          phase_nxt = phase_arrange;
        end
      end
      phase_arrange: begin
        // copy-back done, next stage or finish
        if (phase_last) begin
          if (last_stage) begin
            phase_nxt = phase_done;
            stage_nxt = '0;
          end else begin
            phase_nxt = phase_butterfly;
            stage_nxt = stage + 1'b1;
          end
        end
      end
      phase_done: begin
        phase_nxt = phase_idle;
      end
      default: begin
        phase_nxt = phase_idle;
        stage_nxt = '0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase <= phase_idle;
      stage <= '0;
    end else begin
      phase <= phase_nxt;
      stage <= stage_nxt;
    end
  end

  assign busy = (phase != phase_idle);
  assign done = (phase == phase_done);

endmodule

//--- verilog/fft_addr_gen.sv
module fft_addr_gen (
  input  logic                clk,
  input  logic                rst_n,
  input  fft_pkg::fft_phase_t phase,
  input  fft_pkg::stage_t     stage,
  output logic                phase_last,
  output fft_pkg::fft_addr_t  rd_addr_a,
  output fft_pkg::fft_addr_t  rd_addr_b,
  output fft_pkg::fft_addr_t  wr_addr,
  output logic                work_we,
  output logic                res_we,
  output fft_pkg::tw_addr_t   twiddle_addr,
  output logic                bfly_in_valid
);
  import fft_pkg::*;

  fft_addr_t                 cnt;
  fft_addr_t                 cnt_d1;
  logic                      counting;
  logic                      copy_phase;
  logic                      copy_d1;
  logic                      issue;
  tw_addr_t                  pair;
  fft_addr_t                 half;
  fft_addr_t                 low_mask;
  fft_addr_t                 top_addr;
  fft_addr_t                 res_addr;
  logic [bfly_latency+1:0]   iss_sr;
  fft_addr_t                 top_sr [bfly_latency+2];

  assign counting   = (phase == phase_prepare) || (phase == phase_butterfly) ||
                      (phase == phase_arrange);
  assign copy_phase = (phase == phase_prepare) || (phase == phase_arrange);

  // one pair on odd counts, so even counts leave the work port free for writes
  assign issue = (phase == phase_butterfly) && cnt[0];
  assign pair  = cnt[fft_addr_w-1:1];

  assign half     = fft_addr_t'(1) << stage;
  assign low_mask = half - 1'b1;
  assign top_addr = ((fft_addr_t'(pair) & ~low_mask) << 1) | (fft_addr_t'(pair) & low_mask);

  assign twiddle_addr = (pair & tw_addr_t'(low_mask)) << (stage_t'(fft_stages - 1) - stage);

  always_comb begin
    case (phase)
      phase_prepare:   rd_addr_a = bit_rev(cnt);
      phase_butterfly: rd_addr_a = top_addr;
      default:         rd_addr_a = cnt;
    endcase
  end
  assign rd_addr_b = top_addr | half;

  always_comb begin
    if (phase == phase_drain) begin
      // hold until only the final bottom write remains
      phase_last = ~|iss_sr[bfly_latency:0];
    end else begin
      phase_last = counting && (cnt == fft_addr_t'(fft_points - 1));
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt     <= '0;
      copy_d1 <= 1'b0;
      iss_sr  <= '0;
    end else begin
      if (counting && !phase_last) begin
        cnt <= cnt + 1'b1;
      end else begin
        cnt <= '0;
      end
      copy_d1 <= copy_phase;
      iss_sr  <= {iss_sr[bfly_latency:0], issue};
    end
  end

  // addresses ride along with the strobes
  always_ff @(posedge clk) begin
    cnt_d1    <= cnt;
    top_sr[0] <= top_addr;
    for (int i = 1; i < bfly_latency + 2; i++) begin
      top_sr[i] <= top_sr[i-1];
    end
  end

  assign bfly_in_valid = iss_sr[0];

  // top result first, bottom partner one cycle later
  assign res_we   = iss_sr[bfly_latency] | iss_sr[bfly_latency+1];
  assign res_addr = iss_sr[bfly_latency] ? top_sr[bfly_latency] : (top_sr[bfly_latency+1] | half);

  assign work_we = copy_d1;
  assign wr_addr = res_we ? res_addr : cnt_d1;

endmodule

//--- verilog/fft_top.sv
module fft_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               start,
  input  logic               load_en,
  input  fft_pkg::fft_addr_t load_addr,
  input  fft_pkg::cplx_t     load_data,
  input  fft_pkg::fft_addr_t rd_addr,
  output fft_pkg::cplx_t     rd_data,
  output logic               busy,
  output logic               done
);
  import fft_pkg::*;

  fft_phase_t phase;
  stage_t     stage;
  logic       phase_last;
  fft_addr_t  rd_addr_a;
  fft_addr_t  rd_addr_b;
  fft_addr_t  wr_addr;
  logic       work_we;
  logic       res_we;
  tw_addr_t   twiddle_addr;
  logic       bfly_in_valid;
  logic       in_we;
  logic       from_input;
  fft_addr_t  in_addr;
  fft_addr_t  work_a_addr;
  fft_addr_t  work_b_addr;
  fft_addr_t  res_addr;
  cplx_t      in_rdata;
  cplx_t      work_a_rdata;
  cplx_t      work_b_rdata;
  cplx_t      res_rdata;
  cplx_t      work_wdata;
  cplx_t      twiddle;
  cplx_t      bfly_result;

  fft_sequencer i_fft_sequencer (
    .clk(clk), .rst_n(rst_n), .start(start), .phase_last(phase_last),
    .phase(phase), .stage(stage), .busy(busy), .done(done)
  );

  fft_addr_gen i_fft_addr_gen (
    .clk(clk), .rst_n(rst_n), .phase(phase), .stage(stage),
    .phase_last(phase_last), .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
    .wr_addr(wr_addr), .work_we(work_we), .res_we(res_we),
    .twiddle_addr(twiddle_addr), .bfly_in_valid(bfly_in_valid)
  );

  // loads only land while idle
  assign in_we   = load_en && !busy;
  assign in_addr = (phase == phase_prepare) ? rd_addr_a : load_addr;

  // the only stage 0 butterfly write is the tail of prepare
  assign from_input  = (phase == phase_prepare) || (phase == phase_butterfly && stage == '0);
  assign work_wdata  = from_input ? in_rdata : res_rdata;
  assign work_a_addr = work_we ? wr_addr : ((phase == phase_idle) ? rd_addr : rd_addr_a);
  assign work_b_addr = work_we ? wr_addr : rd_addr_b;
  assign res_addr    = res_we ? wr_addr : rd_addr_a;

  fft_sample_ram input_ram (
    .clk(clk), .we(in_we), .addr(in_addr), .wdata(load_data), .rdata(in_rdata)
  );

  fft_sample_ram work_a_ram (
    .clk(clk), .we(work_we), .addr(work_a_addr), .wdata(work_wdata), .rdata(work_a_rdata)
  );

  fft_sample_ram work_b_ram (
    .clk(clk), .we(work_we), .addr(work_b_addr), .wdata(work_wdata), .rdata(work_b_rdata)
  );

  fft_sample_ram result_ram (
    .clk(clk), .we(res_we), .addr(res_addr), .wdata(bfly_result), .rdata(res_rdata)
  );

  fft_twiddle_rom i_fft_twiddle_rom (
    .clk(clk), .addr(twiddle_addr), .twiddle(twiddle)
  );

  fft_butterfly i_fft_butterfly (
    .clk(clk), .rst_n(rst_n), .in_valid(bfly_in_valid),
    .top(work_a_rdata), .bottom(work_b_rdata), .twiddle(twiddle),
    .out_valid(), .result(bfly_result)
  );

  assign rd_data = work_a_rdata;

endmodule

//--- testbench/fft_props.sv
module fft_props (
  input logic                clk,
  input logic                rst_n,
  input logic                start,
  input fft_pkg::fft_phase_t phase,
  input fft_pkg::stage_t     stage,
  input logic                busy,
  input logic                done
);
  timeunit 1ns;
  timeprecision 100ps;
  import fft_pkg::*;

  int failures = 0;

  // done is a single-cycle pulse
  done_single: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else begin
      $error("done held high for more than one cycle");
      failures++;
    end

  // idle without a start stays idle
  busy_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (phase == phase_idle) && !start |=> !busy)
    else begin
      $error("busy rose without a start");
      failures++;
    end

  // last stage ends the frame instead of wrapping back to stage 0
  stage_range: assert property (@(posedge clk) disable iff (!rst_n)
    (stage == stage_t'(fft_stages - 1)) |=>
      (stage == stage_t'(fft_stages - 1)) || (phase == phase_done))
    else begin
      $error("stage counter wrapped past the last stage");
      failures++;
    end

endmodule

bind fft_sequencer fft_props i_fft_props (
  .clk(clk), .rst_n(rst_n), .start(start), .phase(phase), .stage(stage), .busy(busy),
  .done(done)
);

//--- testbench/fft_tb.sv
module fft_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import fft_pkg::*;

  localparam int n_random = 20;
  // load, start, prepare, four stages of butterfly, drain and arrange, readout, slack
  localparam int frame_cycles = fft_points + 2 + fft_points +
                                fft_stages * (2 * fft_points + 8) + fft_points + 20;
  localparam int cycle_limit = (n_random + 3) * frame_cycles + 100;

  logic      clk;
  logic      rst_n;
  logic      start;
  logic      load_en;
  logic      busy;
  logic      done;
  fft_addr_t load_addr;
  fft_addr_t rd_addr;
  cplx_t     load_data;
  cplx_t     rd_data;

  logic [31:0] rnd_state = 32'h62c6;
  int          cycles = 0;
  int          errors = 0;
  int          tests = 0;
  int          failed = 0;
  int          done_count = 0;
  int          frame_wait = 0;
  logic        busy_q = 1'b0;
  logic        done_q = 1'b0;
  cplx_t       frame [fft_points];
  cplx_t       spectrum [fft_points];

  fft_top i_fft_top (
    .clk(clk), .rst_n(rst_n), .start(start), .load_en(load_en), .load_addr(load_addr),
    .load_data(load_data), .rd_addr(rd_addr), .rd_data(rd_data), .busy(busy), .done(done)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: no finish after %0d cycles", cycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // done must follow busy, and busy must drop right after done
  always @(negedge clk) begin
    if (rst_n) begin
      if (done) begin
        done_count++;
        assert (busy_q) else begin
          $display("done pulse without busy in the cycle before");
          errors++;
        end
      end
      if (done_q) begin
        assert (!busy) else begin
          $display("busy still high after the done pulse");
          errors++;
        end
      end
    end
    busy_q <= busy;
    done_q <= done;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  // uniform in -2^13 .. 2^13
  function automatic logic signed [15:0] rand_sample();
    rnd_state = xorshift(rnd_state);
    return 16'(int'(rnd_state % 32'd16385) - 8192);
  endfunction

  function automatic int round_real(input real x);
    return (x < 0.0) ? -$rtoi(0.5 - x) : $rtoi(x + 0.5);
  endfunction

  function automatic cplx_t twiddle_of(input int k);
    real   ang;
    real   scale;
    cplx_t w;
    ang = 2.0 * 3.14159265358979 * k / fft_points;
    scale = real'(1 << twiddle_frac);
    w.re = 16'(round_real($cos(ang) * scale));
    w.im = 16'(round_real(-$sin(ang) * scale));
    return w;
  endfunction

  // radix-2 DIT, truncating twiddle product and halving at every stage
  function automatic void compute_model();
    cplx_t  cur [fft_points];
    cplx_t  nxt [fft_points];
    cplx_t  w;
    longint p_re;
    longint p_im;
    int     half;
    int     bot;
    int     r;
    for (int i = 0; i < fft_points; i++) begin
      r = 0;
      for (int b = 0; b < fft_addr_w; b++) begin
        r = (r << 1) | ((i >> b) & 1);
      end
      cur[i] = frame[r];
    end
    for (int s = 0; s < fft_stages; s++) begin
      half = 1 << s;
      nxt = cur;
      for (int t = 0; t < fft_points; t++) begin
        if ((t & half) == 0) begin
          bot = t + half;
          w = twiddle_of((t % half) * (fft_points / (2 * half)));
          p_re = (longint'(cur[bot].re) * w.re - longint'(cur[bot].im) * w.im) >>> twiddle_frac;
          p_im = (longint'(cur[bot].re) * w.im + longint'(cur[bot].im) * w.re) >>> twiddle_frac;
          nxt[t].re = 16'((longint'(cur[t].re) + p_re) >>> 1);
          nxt[t].im = 16'((longint'(cur[t].im) + p_im) >>> 1);
          nxt[bot].re = 16'((longint'(cur[t].re) - p_re) >>> 1);
          nxt[bot].im = 16'((longint'(cur[t].im) - p_im) >>> 1);
        end
      end
      cur = nxt;
    end
    spectrum = cur;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string name, input int bin, input logic [15:0] got,
                             input logic [15:0] exp);
    assert (got === exp) else begin
      $display("Error: %s bin %0d = %h, expected %h", name, bin, got, exp);
      errors++;
    end
  endtask

  // load frame unless reusing the last one, start, wait for done, read all bins back
  task automatic run_frame(input string label, input bit disturb, input bit reload);
    int errs0;
    int dones0;
    int waited;
    errs0 = errors;
    dones0 = done_count;
    if (reload) begin
      for (int i = 0; i < fft_points; i++) begin
        load_en = 1'b1;
        load_addr = fft_addr_t'(i);
        load_data = frame[i];
        next_cycle();
      end
    end
    load_en = 1'b0;
    start = 1'b1;
    next_cycle();
    start = 1'b0;
    waited = 0;
    while (!done) begin
      // stray starts and loads early in the frame
      if (disturb && waited < 3 * fft_points) begin
        start = (waited % 5 == 2);
        load_en = 1'b1;
        load_addr = fft_addr_t'(rnd_state);
        load_data = '{re: rand_sample(), im: rand_sample()};
      end else begin
        start = 1'b0;
        load_en = 1'b0;
      end
      next_cycle();
      waited++;
    end
    // every frame takes the same number of cycles
    if (frame_wait == 0) begin
      frame_wait = waited;
    end else begin
      assert (waited == frame_wait) else begin
        $display("done after %0d cycles, the first frame took %0d", waited, frame_wait);
        errors++;
      end
    end
    start = 1'b0;
    load_en = 1'b0;
    next_cycle();
    for (int i = 0; i < fft_points; i++) begin
      rd_addr = fft_addr_t'(i);
      next_cycle();
      check_value("rd_data.re", i, rd_data.re, spectrum[i].re);
      check_value("rd_data.im", i, rd_data.im, spectrum[i].im);
    end
    assert (done_count == dones0 + 1) else begin
      $display("%0d done pulses seen for a single start", done_count - dones0);
      errors++;
    end
    tests++;
    if (errors != errs0) begin
      failed++;
    end
    $display("%s: %s", label, (errors == errs0) ? "ok" : "mismatch");
  endtask

  initial begin
    rst_n = 1'b0;
    start = 1'b0;
    load_en = 1'b0;
    load_addr = '0;
    load_data = '0;
    rd_addr = '0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (8) begin
      next_cycle();
      assert (!busy && !done) else begin
        $display("busy or done raised before any start");
        errors++;
      end
    end
    tests++;
    $display("reset: %s", (errors == 0) ? "ok" : "mismatch");
    if (errors != 0) begin
      failed++;
    end

    // impulse spreads evenly, 0x4000 halved four times
    for (int i = 0; i < fft_points; i++) begin
      frame[i] = '0;
      spectrum[i] = '{re: 16'h0400, im: 16'h0000};
    end
    frame[0].re = 16'h4000;
    run_frame("impulse", 1'b0, 1'b1);

    for (int f = 0; f < n_random; f++) begin
      for (int i = 0; i < fft_points; i++) begin
        frame[i] = '{re: rand_sample(), im: rand_sample()};
      end
      compute_model();
      run_frame($sformatf("random frame %0d", f), 1'b0, 1'b1);
    end

    for (int i = 0; i < fft_points; i++) begin
      frame[i] = '{re: rand_sample(), im: rand_sample()};
    end
    compute_model();
    run_frame("start and load while busy", 1'b1, 1'b1);

    // input buffer must still hold the frame loaded before the stray loads
    run_frame("rerun without reload", 1'b0, 1'b0);

    errors += i_fft_top.i_fft_sequencer.i_fft_props.failures;
    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- list.f
verilog/fft_pkg.sv
verilog/fft_sample_ram.sv
verilog/fft_twiddle_rom.sv
verilog/fft_butterfly.sv
verilog/fft_sequencer.sv
verilog/fft_addr_gen.sv
verilog/fft_top.sv
testbench/fft_props.sv
testbench/fft_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = fft_tb
FILELIST  = list.f
LOG       = sim.log
FAIL_MSG  = *** TEST FAILED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
